/* burst_cache.f */
source/burst_cache_pkg.sv
source/byte_lane_ram.sv
source/burst_cache.sv
source/burst_ram_model.sv
source/cache_top.sv
tb/tb_cache_top.sv

/* source/burst_cache.sv */
// direct-mapped write-back cache; address bits at and above RAM_ADDR_BITS must be zero
`timescale 1ns/1ns

module burst_cache #(
  parameter int LINE_IX_BITS  = 4,
  parameter int RAM_ADDR_BITS = 16,
  parameter int CMD_INTERVAL  = 13
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 enable,
  input  logic [31:0]                          address,
  input  logic [31:0]                          data_in,
  input  logic [3:0]                           write_enable,
  output logic [31:0]                          data_out,
  output logic                                 data_out_ready,
  output logic                                 busy,
  output burst_cache_pkg::br_cmd_e             br_cmd,
  output logic                                 br_cmd_en,
  output logic [RAM_ADDR_BITS-1:0]             br_addr,
  output logic [burst_cache_pkg::BEAT_BITS-1:0] br_wr_data,
  input  logic [burst_cache_pkg::BEAT_BITS-1:0] br_rd_data,
  input  logic                                 br_rd_data_valid
);
  import burst_cache_pkg::*;

  localparam int TAG_BITS = RAM_ADDR_BITS - LINE_IX_BITS - LINE_OFFSET_BITS;
  localparam int VALID_BIT = TAG_BITS;
  localparam int DIRTY_BIT = TAG_BITS + 1;
  localparam int PACE_BITS = $clog2(CMD_INTERVAL + 1);
  localparam int BEAT_IX_BITS = $clog2(BEATS);

  logic [COLUMN_IX_BITS-1:0] column_ix;
  logic [LINE_IX_BITS-1:0]   line_ix;
  logic [TAG_BITS-1:0]       address_tag;
  logic [TAG_BITS-1:0]       cached_tag;
  logic [RAM_ADDR_BITS-1:0]  fill_addr;
  logic [RAM_ADDR_BITS-1:0]  evict_addr;

  logic [31:0] tag_word;
  logic [31:0] tag_din;
  logic [3:0]  tag_we;
  logic [31:0] col_dout [COLUMNS];
  logic [31:0] col_din [COLUMNS];
  logic [3:0]  col_we [COLUMNS];

  fill_state_e           state;
  logic [PACE_BITS-1:0]  pace_cnt;
  logic                  pace_zero;
  logic                  hit;
  logic                  line_dirty;
  logic                  proc_write;
  logic                  issue_evict;
  logic                  issue_fill;
  logic [BEAT_IX_BITS-1:0] rd_beat;
  logic [BEAT_IX_BITS-1:0] wr_beat;
  logic                  rd_in_burst;
  logic                  rd_beat_active;
  logic                  wr_load;

  // |tag|line|column|00|
  assign column_ix   = address[ZERO_BITS +: COLUMN_IX_BITS];
  assign line_ix     = address[LINE_OFFSET_BITS +: LINE_IX_BITS];
  assign address_tag = address[LINE_OFFSET_BITS + LINE_IX_BITS +: TAG_BITS];
  assign fill_addr   = {address[RAM_ADDR_BITS-1:LINE_OFFSET_BITS], LINE_OFFSET_BITS'(0)};

  // tag word holds {dirty, valid, tag}, upper bits zero
  byte_lane_ram #(
    .ADDR_BITS(LINE_IX_BITS)
  ) i_tag_ram (
    .clk         (clk),
    .write_enable(tag_we),
    .address     (line_ix),
    .data_in     (tag_din),
    .data_out    (tag_word)
  );

  generate
    for (genvar i = 0; i < COLUMNS; i++) begin : g_column
      byte_lane_ram #(
        .ADDR_BITS(LINE_IX_BITS)
      ) i_column_ram (
        .clk         (clk),
        .write_enable(col_we[i]),
        .address     (line_ix),
        .data_in     (col_din[i]),
        .data_out    (col_dout[i])
      );
    end
  endgenerate

  assign cached_tag = tag_word[TAG_BITS-1:0];
  assign line_dirty = tag_word[DIRTY_BIT];
  assign hit        = tag_word[VALID_BIT] && (cached_tag == address_tag);
  assign evict_addr = {cached_tag, line_ix, LINE_OFFSET_BITS'(0)};

  assign pace_zero      = (pace_cnt == '0);
  assign busy           = (enable && !hit) || !pace_zero;
  assign data_out       = col_dout[column_ix];
  assign data_out_ready = enable && (write_enable == 4'b0000) && hit;
  assign proc_write     = enable && (write_enable != 4'b0000) && hit;

  assign issue_evict = (state == ST_IDLE) && enable && !hit && pace_zero && line_dirty;
  assign issue_fill  = ((state == ST_IDLE) && enable && !hit && pace_zero && !line_dirty) ||
                       ((state == ST_WRITE_FINISH) && pace_zero);

  // which beat a burst state moves
  always_comb begin
    rd_beat     = '0;
    wr_beat     = '0;
    rd_in_burst = 1'b0;
    wr_load     = 1'b0;
    case (state)
      ST_READ_WAIT: rd_in_burst = 1'b1;
      ST_READ_1: begin
        rd_beat     = BEAT_IX_BITS'(1);
        rd_in_burst = 1'b1;
      end
      ST_READ_2: begin
        rd_beat     = BEAT_IX_BITS'(2);
        rd_in_burst = 1'b1;
      end
      ST_READ_3: begin
        rd_beat     = BEAT_IX_BITS'(3);
        rd_in_burst = 1'b1;
      end
      ST_WRITE_1: begin
        wr_beat = BEAT_IX_BITS'(1);
        wr_load = 1'b1;
      end
      ST_WRITE_2: begin
        wr_beat = BEAT_IX_BITS'(2);
        wr_load = 1'b1;
      end
      ST_WRITE_3: begin
        wr_beat = BEAT_IX_BITS'(3);
        wr_load = 1'b1;
      end
      default: ;
    endcase
  end

  assign rd_beat_active = rd_in_burst && br_rd_data_valid;

  // line fill has priority over the processor write path
  always_comb begin
    tag_we  = '0;
    tag_din = '0;
    for (int i = 0; i < COLUMNS; i++) begin
      col_we[i]  = '0;
      col_din[i] = data_in;
    end
    if (rd_beat_active) begin
      for (int i = 0; i < COLUMNS; i++) begin
        col_din[i] = br_rd_data[(i % 2) * 32 +: 32];
        if ((i / 2) == int'(rd_beat)) begin
          col_we[i] = 4'b1111;
        end
      end
    end else if (state == ST_READ_TAG) begin
      tag_we  = 4'b1111;
      tag_din = 32'({1'b0, 1'b1, address_tag});
    end else if (proc_write) begin
      // write hit marks the line dirty
      tag_we            = 4'b1111;
      tag_din           = 32'({1'b1, 1'b1, address_tag});
      col_we[column_ix] = write_enable;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      pace_cnt  <= '0;
      br_cmd_en <= 1'b0;
    end else begin
      br_cmd_en <= issue_evict || issue_fill;
      if (issue_evict || issue_fill) begin
        pace_cnt <= PACE_BITS'(CMD_INTERVAL);
      end else if (!pace_zero) begin
        pace_cnt <= pace_cnt - 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (issue_evict) begin
            state <= ST_WRITE_1;
          end else if (issue_fill) begin
            state <= ST_READ_WAIT;
          end
        end
        ST_READ_WAIT: state <= br_rd_data_valid ? ST_READ_1 : ST_READ_WAIT;
        ST_READ_1: state <= br_rd_data_valid ? ST_READ_2 : ST_READ_1;
        ST_READ_2: state <= br_rd_data_valid ? ST_READ_3 : ST_READ_2;
        ST_READ_3: state <= br_rd_data_valid ? ST_READ_TAG : ST_READ_3;
        ST_READ_TAG: state <= ST_READ_FINISH;
        ST_READ_FINISH: state <= ST_IDLE;
        ST_WRITE_1: state <= ST_WRITE_2;
        ST_WRITE_2: state <= ST_WRITE_3;
        ST_WRITE_3: state <= ST_WRITE_FINISH;
        // read of the new line waits for the pacing counter
        ST_WRITE_FINISH: state <= pace_zero ? ST_READ_WAIT : ST_WRITE_FINISH;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_evict || issue_fill) begin
      br_cmd  <= issue_evict ? BR_WRITE : BR_READ;
      br_addr <= issue_evict ? evict_addr : fill_addr;
    end
    // low column of a pair goes in the low half of the beat
    if (issue_evict || wr_load) begin
      br_wr_data <= {col_dout[{wr_beat, 1'b1}], col_dout[{wr_beat, 1'b0}]};
    end
  end

  a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en high for two cycles");

  a_busy_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
    (state != ST_IDLE) |-> busy)
    else $error("busy low while line transfer in progress");

endmodule

/* source/burst_cache_pkg.sv */
// fixed line geometry of eight 32-bit words moved as four 64-bit beats; byte addressing only
package burst_cache_pkg;

  // low address bits that pick a byte inside a word, ignored by the cache
  localparam int ZERO_BITS = 2;
  localparam int COLUMN_IX_BITS = 3;
  localparam int COLUMNS = 2 ** COLUMN_IX_BITS;
  // a line starts on this alignment in RAM
  localparam int LINE_OFFSET_BITS = COLUMN_IX_BITS + ZERO_BITS;
  localparam int BEAT_BITS = 64;
  localparam int BEATS = 4;

  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_cmd_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_READ_WAIT,
    ST_READ_1,
    ST_READ_2,
    ST_READ_3,
    ST_READ_TAG,
    ST_READ_FINISH,
    ST_WRITE_1,
    ST_WRITE_2,
    ST_WRITE_3,
    ST_WRITE_FINISH
  } fill_state_e;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_LATENCY,
    RS_READ_BEATS,
    RS_WRITE_BEATS
  } ram_state_e;

endpackage

/* source/burst_ram_model.sv */
// burst RAM model with byte addresses only; READ_LATENCY must be at least 2
`timescale 1ns/1ns

module burst_ram_model #(
  parameter int RAM_ADDR_BITS = 16,
  parameter int READ_LATENCY  = 6,
  parameter int CMD_INTERVAL  = 13
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  burst_cache_pkg::br_cmd_e              br_cmd,
  input  logic                                  br_cmd_en,
  input  logic [RAM_ADDR_BITS-1:0]              br_addr,
  input  logic [burst_cache_pkg::BEAT_BITS-1:0] br_wr_data,
  output logic [burst_cache_pkg::BEAT_BITS-1:0] br_rd_data,
  output logic                                  br_rd_data_valid
);
  import burst_cache_pkg::*;

  localparam int WORD_ADDR_BITS = RAM_ADDR_BITS - ZERO_BITS;
  localparam int LINE_ADDR_BITS = RAM_ADDR_BITS - LINE_OFFSET_BITS;
  localparam int BEAT_IX_BITS = COLUMN_IX_BITS - 1;
  localparam int LAT_BITS = $clog2(READ_LATENCY + 1);
  localparam int GAP_BITS = $clog2(CMD_INTERVAL + 2);

  logic [31:0] mem [2**WORD_ADDR_BITS];

  ram_state_e                state;
  logic [LINE_ADDR_BITS-1:0] line_q;
  logic [LINE_ADDR_BITS-1:0] line_sel;
  logic [BEAT_IX_BITS-1:0]   beat;
  logic [BEAT_IX_BITS-1:0]   beat_sel;
  logic [LAT_BITS-1:0]       lat_cnt;
  logic [GAP_BITS-1:0]       gap_cnt;
  logic [WORD_ADDR_BITS-1:0] lo_word;
  logic [WORD_ADDR_BITS-1:0] hi_word;
  logic                      wr_en;

  // each word starts as its byte address xor 5A5A0000
  initial begin
    for (int i = 0; i < 2**WORD_ADDR_BITS; i++) begin
      mem[i] = 32'(i << ZERO_BITS) ^ 32'h5A5A_0000;
    end
  end

  // beat 0 of a write is taken straight off the strobe cycle
  assign line_sel = (state == RS_IDLE) ? br_addr[RAM_ADDR_BITS-1:LINE_OFFSET_BITS] : line_q;
  assign beat_sel = (state == RS_IDLE) ? '0 : beat;
  assign lo_word  = {line_sel, beat_sel, 1'b0};
  assign hi_word  = {line_sel, beat_sel, 1'b1};
  assign wr_en    = ((state == RS_IDLE) && br_cmd_en && (br_cmd == BR_WRITE)) ||
                    (state == RS_WRITE_BEATS);

  always @(posedge clk) begin
    if (wr_en) begin
      mem[lo_word] <= br_wr_data[31:0];
      mem[hi_word] <= br_wr_data[63:32];
    end
    if ((state == RS_IDLE) && br_cmd_en) begin
      line_q <= br_addr[RAM_ADDR_BITS-1:LINE_OFFSET_BITS];
    end
  end

  assign br_rd_data       = {mem[hi_word], mem[lo_word]};
  assign br_rd_data_valid = (state == RS_READ_BEATS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RS_IDLE;
      beat    <= '0;
      lat_cnt <= '0;
      gap_cnt <= GAP_BITS'(CMD_INTERVAL + 1);
    end else begin
      // cycles since the last strobe, saturating
      if (br_cmd_en) begin
        gap_cnt <= GAP_BITS'(1);
      end else if (gap_cnt != GAP_BITS'(CMD_INTERVAL + 1)) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
      case (state)
        RS_IDLE: begin
          if (br_cmd_en && (br_cmd == BR_WRITE)) begin
            beat  <= BEAT_IX_BITS'(1);
            state <= RS_WRITE_BEATS;
          end else if (br_cmd_en) begin
            lat_cnt <= LAT_BITS'(READ_LATENCY - 1);
            state   <= RS_LATENCY;
          end
        end
        RS_LATENCY: begin
          if (lat_cnt == LAT_BITS'(1)) begin
            beat  <= '0;
            state <= RS_READ_BEATS;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        RS_READ_BEATS, RS_WRITE_BEATS: begin
          beat <= beat + 1'b1;
          if (beat == BEAT_IX_BITS'(BEATS - 1)) begin
            state <= RS_IDLE;
          end
        end
        default: state <= RS_IDLE;
      endcase
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> (state == RS_IDLE))
    else $error("command strobe during a burst");

  a_pacing: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> (gap_cnt >= CMD_INTERVAL + 1))
    else $error("command strobes closer than %0d cycles", CMD_INTERVAL + 1);

  a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> (br_addr[LINE_OFFSET_BITS-1:0] == '0))
    else $error("burst address 0x%h not line aligned", br_addr);

endmodule

/* source/byte_lane_ram.sv */
// 32-bit words with byte write enables; contents start at zero and are never cleared by reset
`timescale 1ns/1ns

module byte_lane_ram #(
  parameter int ADDR_BITS = 4
) (
  input  logic                 clk,
  input  logic [3:0]           write_enable,
  input  logic [ADDR_BITS-1:0] address,
  input  logic [31:0]          data_in,
  output logic [31:0]          data_out
);

  logic [31:0] mem [2**ADDR_BITS];

  // power-up contents, keeps tag valid bits low
  initial begin
    for (int i = 0; i < 2**ADDR_BITS; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
      end
    end
  end

  // asynchronous read
  assign data_out = mem[address];

endmodule

/* source/cache_top.sv */
// closed cache subsystem with its own burst RAM model; processor must hold inputs while busy
`timescale 1ns/1ns

module cache_top #(
  parameter int LINE_IX_BITS  = 4,
  parameter int RAM_ADDR_BITS = 16,
  parameter int CMD_INTERVAL  = 13,
  parameter int READ_LATENCY  = 6
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic [31:0] address,
  input  logic [3:0]  write_enable,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy
);
  import burst_cache_pkg::*;

  br_cmd_e                  br_cmd;
  logic                     br_cmd_en;
  logic [RAM_ADDR_BITS-1:0] br_addr;
  logic [BEAT_BITS-1:0]     br_wr_data;
  logic [BEAT_BITS-1:0]     br_rd_data;
  logic                     br_rd_data_valid;

  burst_cache #(
    .LINE_IX_BITS (LINE_IX_BITS),
    .RAM_ADDR_BITS(RAM_ADDR_BITS),
    .CMD_INTERVAL (CMD_INTERVAL)
  ) i_cache (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .address         (address),
    .data_in         (data_in),
    .write_enable    (write_enable),
    .data_out        (data_out),
    .data_out_ready  (data_out_ready),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram_model #(
    .RAM_ADDR_BITS(RAM_ADDR_BITS),
    .READ_LATENCY (READ_LATENCY),
    .CMD_INTERVAL (CMD_INTERVAL)
  ) i_ram (
    .clk             (clk),
    .rst_n           (rst_n),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

endmodule

/* tb/cache_patterns.txt */
# op address mask wdata expected, all hex; expected is ignored for W
# untouched RAM reads as address xor 5A5A0000
R 00000040 0 00000000 5A5A0040
R 00000044 0 00000000 5A5A0044
R 0000005C 0 00000000 5A5A005C
W 00000048 3 AABBCCDD 00000000
R 00000048 0 00000000 5A5ACCDD
W 00000040 C 11223344 00000000
W 0000005C F DEADBEEF 00000000
R 00000240 0 00000000 5A5A0240
R 00000244 0 00000000 5A5A0244
R 00000048 0 00000000 5A5ACCDD
R 00000040 0 00000000 11220040
R 0000005C 0 00000000 DEADBEEF
R 0000004C 0 00000000 5A5A004C
R 00000440 0 00000000 5A5A0440
R 00000240 0 00000000 5A5A0240
R 00000454 0 00000000 5A5A0454
R 00000254 0 00000000 5A5A0254
W 000001A4 6 01020304 00000000
R 000001A4 0 00000000 5A0203A4
R 000001A0 0 00000000 5A5A01A0
R 0000FDB8 0 00000000 5A5AFDB8
R 000001A4 0 00000000 5A0203A4
R 00000000 0 00000000 5A5A0000
R 0000FFFC 0 00000000 5A5AFFFC
W 0000FFFC 8 99000000 00000000
R 0000FFFC 0 00000000 995AFFFC

/* tb/tb_cache_top.sv */
// runs from the project root so that tb/cache_patterns.txt is found; parameters match the RTL defaults
`timescale 1ns/1ns

module tb_cache_top;

  localparam int LINE_IX_BITS       = 4;
  localparam int RAM_ADDR_BITS      = 16;
  localparam int CMD_INTERVAL       = 13;
  localparam int READ_LATENCY       = 6;
  localparam int CLK_PERIOD         = 8;
  // eight words of four bytes per line
  localparam int LINE_OFFSET        = 5;
  localparam int TAG_BITS           = RAM_ADDR_BITS - LINE_IX_BITS - LINE_OFFSET;
  localparam int MAX_WAIT           = 100;
  localparam int CYCLES_PER_PATTERN = 200;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [31:0] address;
  logic [3:0]  write_enable;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;

  logic [7:0]  op_q [$];
  logic [31:0] addr_q [$];
  logic [3:0]  mask_q [$];
  logic [31:0] wdata_q [$];
  logic [31:0] expect_q [$];

  int errors;
  bit loaded;
  // expected cache contents with one tag per line index
  int shadow_tag [2**LINE_IX_BITS];
  bit shadow_valid [2**LINE_IX_BITS];

  cache_top #(
    .LINE_IX_BITS (LINE_IX_BITS),
    .RAM_ADDR_BITS(RAM_ADDR_BITS),
    .CMD_INTERVAL (CMD_INTERVAL),
    .READ_LATENCY (READ_LATENCY)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .address       (address),
    .write_enable  (write_enable),
    .data_in       (data_in),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic load_patterns();
    int          fd;
    int          code;
    logic [63:0] token;
    logic [31:0] a;
    logic [31:0] m;
    logic [31:0] w;
    logic [31:0] e;
    logic [8*128-1:0] rest;
    fd = $fopen("tb/cache_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/cache_patterns.txt");
      errors++;
      return;
    end
    code = $fscanf(fd, "%s", token);
    while (code == 1) begin
      if (token == "#") begin
        code = $fgets(rest, fd);
      end else if (token == "R" || token == "W") begin
        code = $fscanf(fd, "%h %h %h %h", a, m, w, e);
        if (code != 4) begin
          $display("malformed pattern line after entry %0d", addr_q.size());
          errors++;
          break;
        end
        op_q.push_back(token[7:0]);
        addr_q.push_back(a);
        mask_q.push_back(m[3:0]);
        wdata_q.push_back(w);
        expect_q.push_back(e);
      end else begin
        $display("unknown operation in pattern file after entry %0d", addr_q.size());
        errors++;
        break;
      end
      code = $fscanf(fd, "%s", token);
    end
    $fclose(fd);
  endtask

  // one processor access entered 1 ns after a rising edge
  task automatic run_access(input int n, output bit timed_out);
    logic [31:0] addr;
    bit          is_read;
    bit          expect_hit;
    int          ix;
    int          tg;
    int          waited;
    addr       = addr_q[n];
    is_read    = (op_q[n] == "R");
    ix         = (addr >> LINE_OFFSET) % (2**LINE_IX_BITS);
    tg         = (addr >> (LINE_OFFSET + LINE_IX_BITS)) % (2**TAG_BITS);
    expect_hit = shadow_valid[ix] && (shadow_tag[ix] == tg);
    timed_out  = 1'b0;

    enable       = 1'b1;
    address      = addr;
    write_enable = is_read ? 4'b0000 : mask_q[n];
    data_in      = wdata_q[n];

    @(negedge clk);
    if (busy !== !expect_hit) begin
      $display("ERROR busy: expected 0x%h, got 0x%h at access %0d", !expect_hit, busy, n);
      errors++;
    end
    waited = 0;
    while (busy !== 1'b0 && waited < MAX_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (busy !== 1'b0) begin
      $display("busy never fell within %0d cycles on access %0d to address 0x%h",
               MAX_WAIT, n, addr);
      errors++;
      timed_out = 1'b1;
      return;
    end

    if (is_read) begin
      if (data_out_ready !== 1'b1) begin
        $display("ERROR data_out_ready: expected 0x1, got 0x%h at access %0d", data_out_ready, n);
        errors++;
      end
      if (data_out !== expect_q[n]) begin
        $display("ERROR data_out: expected 0x%08h, got 0x%08h at access %0d address 0x%h",
                 expect_q[n], data_out, n, addr);
        errors++;
      end
      @(posedge clk);
      #1;
    end else begin
      if (data_out_ready !== 1'b0) begin
        $display("ERROR data_out_ready: expected 0x0, got 0x%h at access %0d", data_out_ready, n);
        errors++;
      end
      // write lands on this edge and the inputs stay one more cycle
      @(posedge clk);
      @(negedge clk);
      if (data_out_ready !== 1'b0) begin
        $display("ERROR data_out_ready: expected 0x0, got 0x%h after write %0d",
                 data_out_ready, n);
        errors++;
      end
      @(posedge clk);
      #1;
    end
    enable       = 1'b0;
    write_enable = 4'b0000;
    shadow_valid[ix] = 1'b1;
    shadow_tag[ix]   = tg;
  endtask

  initial begin
    int gap;
    bit timed_out;
    rst_n        = 1'b0;
    enable       = 1'b0;
    address      = '0;
    write_enable = '0;
    data_in      = '0;
    errors       = 0;
    loaded       = 1'b0;
    timed_out    = 1'b0;
    void'($urandom(69));
    for (int i = 0; i < 2**LINE_IX_BITS; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i]   = 0;
    end
    load_patterns();
    if (addr_q.size() == 0) begin
      $display("no accesses were loaded from the pattern file");
      errors++;
    end
    loaded = 1'b1;

    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    if (busy !== 1'b0) begin
      $display("ERROR busy: expected 0x0, got 0x%h after reset", busy);
      errors++;
    end
    if (data_out_ready !== 1'b0) begin
      $display("ERROR data_out_ready: expected 0x0, got 0x%h after reset", data_out_ready);
      errors++;
    end
    @(posedge clk);
    #1;

    for (int n = 0; n < addr_q.size() && !timed_out; n++) begin
      run_access(n, timed_out);
      gap = $urandom % 4;
      if (gap > 0 && !timed_out) begin
        repeat (gap) @(posedge clk);
        #1;
      end
    end

    $display("errors: %0d over %0d accesses", errors, addr_q.size());
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog sized from the number of accesses plus room for reset
  initial begin
    wait (loaded);
    #((addr_q.size() + 1) * CYCLES_PER_PATTERN * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not complete",
             (addr_q.size() + 1) * CYCLES_PER_PATTERN);
    $display("Some tests failed");
    $finish;
  end

endmodule
